//--- sim.f
+incdir+include
verilog/spi_protocol_pkg.sv
verilog/motion_pkg.sv
verilog/dda_axis.sv
verilog/move_buffer.sv
verilog/move_sequencer.sv
verilog/word_cmd_parser.sv
verilog/motion_controller_top.sv
test/tb_motion_controller.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_motion_controller
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/tb_host_tasks.svh
// Host word tasks and reference model; call right after a rising CLK edge, one word per 4 cycles
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Strobe high 2 cycles, low 2 cycles, reply read 4 cycles after the rise
task automatic send_word(input word_t w, output word_t reply);
  word_data_received <= w;
  word_received      <= 1'b1;
  repeat (2) @(posedge CLK);
  word_received <= 1'b0;
  repeat (2) @(posedge CLK);
  reply = word_send_data;
endtask

task automatic status_read(input logic [7:0] idx, output word_t reply);
  send_word({8'hF1, 48'h0, idx}, reply);
endtask

// Header answers the old value, second word writes
task automatic config_access(input logic [7:0] idx, input logic [31:0] value,
                             output word_t old_value);
  word_t ignored;
  send_word({8'hF2, 48'h0, idx}, old_value);
  send_word({32'h0, value}, ignored);
endtask

task automatic send_move(input logic [31:0] duration, input logic [num_motors-1:0] dirs,
                         input logic [num_motors-1:0][31:0] incs);
  word_t header;
  word_t ignored;
  header                 = '0;
  header[63:56]          = 8'h01;
  header[num_motors-1:0] = dirs;  // Forward where set
  send_word(header, ignored);
  send_word({32'h0, duration}, ignored);
  for (int n = 0; n < num_motors; n++) begin
    send_word({32'h0, incs[n]}, ignored);
  end
endtask

// Carries out of a 32-bit accumulator over duration ticks
function automatic longint expected_steps(input logic [31:0] duration, input logic [31:0] inc);
  logic [63:0] product;
  product = {32'h0, duration} * {32'h0, inc};
  return longint'(product >> 32);
endfunction

// Only accepted moves go through here
task automatic model_move(input logic [31:0] duration, input logic [num_motors-1:0] dirs,
                          input logic [num_motors-1:0][31:0] incs);
  longint steps;
  for (int n = 0; n < num_motors; n++) begin
    steps = expected_steps(duration, incs[n]);
    if (dirs[n]) exp_pos[n] = exp_pos[n] + steps;
    else exp_pos[n] = exp_pos[n] - steps;
  end
endtask

task automatic wait_for_moves(input longint target);
  while (done_count < target) @(posedge CLK);
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(posedge CLK);
endtask

`endif

//--- test/tb_motion_controller.sv
// Two axes, two buffer slots; moves run at a DDA divisor of 4 written over the config path
`timescale 1ns/1ps

module tb_motion_controller;
  import spi_protocol_pkg::*;

  localparam int num_motors          = 2;
  localparam int buffer_size         = 2;
  localparam int tb_divisor          = 4;
  localparam int random_moves        = 6;
  localparam int max_random_duration = 40;
  // Each move counted as duration+1 ticks
  localparam int total_ticks = (200 + 1) + (400 + 1) + 3 * (50 + 1)
                               + random_moves * (max_random_duration + 1);
  localparam int timeout_cycles = 2 * total_ticks * tb_divisor + 2000;

  logic                  CLK;
  logic                  resetn;
  word_t                 word_data_received;
  logic                  word_received;
  word_t                 word_send_data;
  logic                  buffer_dtr;
  logic                  move_done;
  logic [num_motors-1:0] step;
  logic [num_motors-1:0] dir;
  logic [num_motors-1:0] enable;

  longint exp_pos    [num_motors] = '{default: 0};
  longint step_count [num_motors] = '{default: 0};
  longint done_count  = 0;
  int     cycle_count = 0;

  motion_controller_top #(.num_motors(num_motors), .buffer_size(buffer_size)) DUT (
    .CLK(CLK), .resetn(resetn),
    .word_data_received(word_data_received), .word_received(word_received),
    .word_send_data(word_send_data), .buffer_dtr(buffer_dtr), .move_done(move_done),
    .step(step), .dir(dir), .enable(enable)
  );

  `include "tb_host_tasks.svh"

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic check_value(input string test, input longint expected, input longint actual);
    assert (actual == expected) else begin
      $display("Fail %s expected %0d actual %0d", test, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_positions(input string test);
    word_t reply;
    for (int n = 0; n < num_motors; n++) begin
      status_read(8'(2 + n), reply);  // Position registers start at index 2
      check_value(test, exp_pos[n], longint'(reply));
    end
  endtask

  // Pulses counted at the falling edge where outputs are settled
  always @(negedge CLK) begin
    if (move_done) done_count++;
    for (int n = 0; n < num_motors; n++) begin
      if (step[n]) step_count[n]++;
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  a_reset_outputs: assert property (@(posedge CLK)
    resetn |=> (buffer_dtr && !move_done && step == '0 && word_send_data == '0))
    else begin
      $display("Fail reset_defaults expected dtr 1 done 0 step 0 actual dtr %0b done %0b step %0b",
               buffer_dtr, move_done, step);
      $display("CHECKS FAILED");
      $fatal(1);
    end

  a_step_single: assert property (@(posedge CLK) disable iff (resetn)
    (step != '0) |=> ((step & $past(step)) == '0))
    else begin
      $display("A step pulse lasted longer than one cycle, step is %0b", step);
      $display("CHECKS FAILED");
      $fatal(1);
    end

  initial begin
    word_t                       reply;
    longint                      base_done;
    longint                      base_steps [num_motors];
    logic [num_motors-1:0][31:0] incs;
    logic [num_motors-1:0]       dirs;
    logic [31:0]                 dur;

    void'($urandom(25393));
    resetn             <= 1'b1;
    word_received      <= 1'b0;
    word_data_received <= '0;
    repeat (4) @(posedge CLK);
    resetn <= 1'b0;
    @(posedge CLK);

    // reset_defaults
    check_value("reset_defaults", 1, longint'(buffer_dtr));
    check_value("reset_defaults", 0, longint'(move_done));
    check_value("reset_defaults", 0, longint'(step));
    check_value("reset_defaults", 0, longint'(enable));
    status_read(8'd0, reply);
    check_value("reset_defaults", 64'h1_0000, longint'(reply));  // Version 1.0.0
    status_read(8'd1, reply);
    check_value("reset_defaults", num_motors + (buffer_size << 8), longint'(reply));
    status_read(8'd9, reply);
    check_value("reset_defaults", 0, longint'(reply));
    config_access(8'd1, 32'd32, reply);  // Same divisor written back
    check_value("reset_defaults", 32, longint'(reply));

    // config_roundtrip
    config_access(8'd0, 32'd3, reply);
    check_value("config_roundtrip", 0, longint'(reply));
    config_access(8'd0, 32'd3, reply);
    check_value("config_roundtrip", 3, longint'(reply));
    check_value("config_roundtrip", 3, longint'(enable));
    config_access(8'd1, 32'(tb_divisor), reply);
    check_value("config_roundtrip", 32, longint'(reply));
    config_access(8'd1, 32'(tb_divisor), reply);
    check_value("config_roundtrip", tb_divisor, longint'(reply));

    // single_move, axis 0 forward and axis 1 back
    base_done = done_count;
    for (int n = 0; n < num_motors; n++) base_steps[n] = step_count[n];
    incs[0] = 32'h4000_0000;
    incs[1] = 32'hA000_0001;
    dirs    = 2'b01;
    send_move(32'd200, dirs, incs);
    model_move(32'd200, dirs, incs);
    wait_for_moves(base_done + 1);
    idle_cycles(3 * tb_divisor);
    check_value("single_move", 1, done_count - base_done);
    check_value("single_move", longint'(dirs), longint'(dir));
    for (int n = 0; n < num_motors; n++) begin
      check_value("single_move", expected_steps(32'd200, incs[n]), step_count[n] - base_steps[n]);
    end
    check_positions("single_move");

    // buffer_full
    base_done = done_count;
    incs[0] = 32'h2000_0000;
    incs[1] = 32'h0800_0000;
    dirs    = 2'b11;
    send_move(32'd400, dirs, incs);
    model_move(32'd400, dirs, incs);
    idle_cycles(4);  // Long move leaves the ring
    incs[0] = 32'h8000_0000;
    incs[1] = 32'h3000_0000;
    dirs    = 2'b10;
    for (int k = 0; k < buffer_size; k++) begin
      send_move(32'd50, dirs, incs);
      model_move(32'd50, dirs, incs);
    end
    idle_cycles(2);
    check_value("buffer_full", 0, longint'(buffer_dtr));
    incs[0] = 32'hFFFF_FFFF;  // Would show up in the positions if kept
    incs[1] = 32'hFFFF_FFFF;
    send_move(32'd50, 2'b11, incs);
    wait_for_moves(base_done + 1 + buffer_size);
    idle_cycles(60 * tb_divisor);
    check_value("buffer_full", 1 + buffer_size, done_count - base_done);
    check_value("buffer_full", longint'(dirs), longint'(dir));
    check_positions("buffer_full");

    // random_moves
    base_done = done_count;
    for (int k = 0; k < random_moves; k++) begin
      dur  = $urandom_range(max_random_duration, 1);
      dirs = num_motors'($urandom());
      for (int n = 0; n < num_motors; n++) incs[n] = $urandom();
      @(posedge CLK);  // Last push has landed in the ring
      while (!buffer_dtr) @(posedge CLK);
      send_move(dur, dirs, incs);
      model_move(dur, dirs, incs);
    end
    wait_for_moves(base_done + random_moves);
    idle_cycles(3 * tb_divisor);
    check_value("random_moves", random_moves, done_count - base_done);
    check_positions("random_moves");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- verilog/motion_controller_top.sv
// num_motors from 1 to max_motors and buffer_size a power of two; moves sent while full are lost
`timescale 1ns/1ps

module motion_controller_top #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                    CLK,
  input  logic                    resetn,
  input  spi_protocol_pkg::word_t word_data_received,
  input  logic                    word_received,
  output spi_protocol_pkg::word_t word_send_data,
  output logic                    buffer_dtr,
  output logic                    move_done,
  output logic [num_motors-1:0]   step,
  output logic [num_motors-1:0]   dir,
  output logic [num_motors-1:0]   enable
);
  import motion_pkg::*;

  logic                                 push;
  logic                                 take;
  logic                                 slot_valid;
  move_cmd_t                            new_move;
  move_cmd_t                            slot;
  axis_ctrl_t                           axis_ctrl;
  position_vec_t                        positions;
  logic [7:0]                           clock_divisor;
  logic [max_motors-1:0]                dir_mask;
  logic [max_motors-1:0][dda_bits-1:0]  increments;

  word_cmd_parser #(.num_motors(num_motors), .buffer_size(buffer_size)) u_parser (
    .CLK(CLK), .resetn(resetn),
    .word_data_received(word_data_received), .word_received(word_received),
    .positions(positions), .word_send_data(word_send_data),
    .push(push), .move(new_move),
    .enable_mask(enable), .clock_divisor(clock_divisor)  // Enable register drives the pins
  );

  move_buffer #(.buffer_size(buffer_size)) u_buffer (
    .CLK(CLK), .resetn(resetn), .push(push), .move(new_move), .take(take),
    .slot(slot), .slot_valid(slot_valid), .buffer_dtr(buffer_dtr)
  );

  move_sequencer u_sequencer (
    .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor),
    .slot(slot), .slot_valid(slot_valid), .take(take), .axis_ctrl(axis_ctrl),
    .move_done(move_done), .dir_mask(dir_mask), .increments(increments)
  );

  for (genvar g = 0; g < max_motors; g++) begin : g_axis
    if (g < num_motors) begin : g_live
      assign dir[g] = dir_mask[g];
      dda_axis u_axis (
        .CLK(CLK), .resetn(resetn), .axis_ctrl(axis_ctrl),
        .increment(increments[g]), .dir(dir_mask[g]),
        .step(step[g]), .position(positions[g])
      );
    end else begin : g_unused
      assign positions[g] = '0;  // Absent axis reads as zero
    end
  end

endmodule

//--- verilog/word_cmd_parser.sv
// Host data must stay stable while word_received is high; each reply appears 2 cycles after the word
`timescale 1ns/1ps

module word_cmd_parser #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                      CLK,
  input  logic                      resetn,
  input  spi_protocol_pkg::word_t   word_data_received,
  input  logic                      word_received,
  input  motion_pkg::position_vec_t positions,
  output spi_protocol_pkg::word_t   word_send_data,
  output logic                      push,
  output motion_pkg::move_cmd_t     move,
  output logic [num_motors-1:0]     enable_mask,
  output logic [7:0]                clock_divisor
);
  import spi_protocol_pkg::*;
  import motion_pkg::*;

  localparam int cnt_bits  = $clog2(num_motors + 2);
  localparam int last_word = num_motors + 1;  // Duration plus one increment per axis

  if (num_motors < 1 || num_motors > max_motors) begin : g_bad_motors
    $error("num_motors must lie between 1 and max_motors");
  end

  logic [1:0]          rx_sync;     // Current and previous word_received sample
  logic                word_event;  // One cycle per counted word
  word_t               word_in_q;
  word_t               word_q;      // Word under decode
  opcode_e             hdr_op;
  opcode_e             cur_op;
  logic                in_txn;      // Waiting for follow-up words
  logic [cnt_bits-1:0] word_cnt;
  logic [7:0]          cfg_idx;
  move_cmd_t           move_asm;

  assign hdr_op = opcode_e'(word_q[word_bits-1 -: 8]);
  assign move   = move_asm;

  function automatic word_t status_read(input logic [7:0] idx);
    word_t                    r;
    logic [position_bits-1:0] p;
    r = '0;
    p = '0;
    if (idx == status_version) begin
      r = version_word;
    end else if (idx == status_channel_info) begin
      r[7:0]  = 8'(num_motors);
      r[15:8] = 8'(buffer_size);
    end
    for (int n = 0; n < num_motors; n++) begin
      if (idx == status_position_start + n) begin
        p = positions[n];
        r = {{(word_bits - position_bits){p[position_bits-1]}}, p};  // Sign extend
      end
    end
    return r;
  endfunction

  function automatic word_t config_read(input logic [7:0] idx);
    word_t r;
    r = '0;
    if (idx == config_enable) r[num_motors-1:0] = enable_mask;
    else if (idx == config_clocks) r[7:0] = clock_divisor;
    return r;
  endfunction

  // Rising edge of word_received, registered once more for the 2 cycle reply
  always_ff @(posedge CLK) begin
    if (resetn) begin
      rx_sync    <= '0;
      word_event <= 1'b0;
    end else begin
      rx_sync    <= {rx_sync[0], word_received};
      word_event <= rx_sync[0] & ~rx_sync[1];
    end
  end

  always_ff @(posedge CLK) begin
    word_in_q <= word_data_received;
    if (rx_sync[0] & ~rx_sync[1]) word_q <= word_in_q;  // Data seen with the edge
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_send_data <= '0;
      push           <= 1'b0;
      in_txn         <= 1'b0;
      cur_op         <= cmd_status_reg;
      word_cnt       <= '0;
      cfg_idx        <= '0;
      enable_mask    <= '0;
      clock_divisor  <= default_clock_divisor;
    end else begin
      push <= 1'b0;
      if (word_event) begin
        word_send_data <= '0;  // Move words and unknowns answer zero
        if (!in_txn) begin
          cur_op <= hdr_op;
          case (hdr_op)
            cmd_coordinated_step: begin
              in_txn   <= 1'b1;
              word_cnt <= cnt_bits'(1);
            end
            cmd_status_reg: word_send_data <= status_read(word_q[7:0]);
            cmd_config_reg: begin
              in_txn         <= 1'b1;
              cfg_idx        <= word_q[7:0];
              word_send_data <= config_read(word_q[7:0]);
            end
            default: ;
          endcase
        end else if (cur_op == cmd_config_reg) begin
          // Second config word writes
          in_txn <= 1'b0;
          if (cfg_idx == config_enable) enable_mask <= word_q[num_motors-1:0];
          else if (cfg_idx == config_clocks) clock_divisor <= word_q[7:0];
        end else if (word_cnt == cnt_bits'(last_word)) begin
          in_txn   <= 1'b0;
          word_cnt <= '0;
          push     <= 1'b1;  // Move complete
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Move assembly
  always_ff @(posedge CLK) begin
    if (word_event) begin
      if (!in_txn && hdr_op == cmd_coordinated_step) begin
        move_asm.duration   <= '0;
        move_asm.increments <= '0;
        move_asm.dir_mask   <= max_motors'(word_q[num_motors-1:0]);
      end else if (in_txn && cur_op == cmd_coordinated_step) begin
        if (word_cnt == cnt_bits'(1)) move_asm.duration <= word_q[duration_bits-1:0];
        else move_asm.increments[word_cnt - cnt_bits'(2)] <= word_q[dda_bits-1:0];
      end
    end
  end

  a_word_cnt_range: assert property (@(posedge CLK) disable iff (resetn)
    word_cnt <= cnt_bits'(last_word));

endmodule

//--- verilog/move_sequencer.sv
// Divisors below 2 run the DDA tick at half the clock; a move lasts duration ticks, 0 acts as 1
`timescale 1ns/1ps

module move_sequencer (
  input  logic                                                    CLK,
  input  logic                                                    resetn,
  input  logic [7:0]                                              clock_divisor,
  input  motion_pkg::move_cmd_t                                   slot,
  input  logic                                                    slot_valid,
  output logic                                                    take,
  output motion_pkg::axis_ctrl_t                                  axis_ctrl,
  output logic                                                    move_done,
  output logic [motion_pkg::max_motors-1:0]                       dir_mask,
  output logic [motion_pkg::max_motors-1:0][motion_pkg::dda_bits-1:0] increments
);
  import motion_pkg::*;

  logic [7:0]               div_cnt;
  logic [7:0]               div_limit;
  logic                     tick;
  seq_state_e               state;
  logic [duration_bits-1:0] ticks_left;

  assign div_limit = (clock_divisor < 8'd2) ? 8'd1 : clock_divisor - 8'd1;

  // Free-running tick divider
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt >= div_limit) begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

  assign take = (state == idle) && slot_valid;  // Frees the slot as it is captured

  always_comb begin
    axis_ctrl.tick    = tick;
    axis_ctrl.load    = (state == load);
    axis_ctrl.running = (state == run);
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= idle;
      ticks_left <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        idle: if (slot_valid) begin
          ticks_left <= slot.duration;
          state      <= load;
        end
        load: state <= run;  // Axes clear accumulators here
        run: if (tick) begin
          if (ticks_left <= duration_bits'(1)) begin
            move_done <= 1'b1;
            state     <= idle;
          end else begin
            ticks_left <= ticks_left - 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Loaded move fields held for the axes
  always_ff @(posedge CLK) begin
    if (take) begin
      dir_mask   <= slot.dir_mask;
      increments <= slot.increments;
    end
  end

  a_done_pulse: assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done);

endmodule

//--- verilog/move_buffer.sv
// Ring of buffer_size move slots; a push while full is dropped, so the host must watch buffer_dtr
`timescale 1ns/1ps

module move_buffer #(
  parameter int buffer_size = 2
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  push,
  input  motion_pkg::move_cmd_t move,
  input  logic                  take,
  output motion_pkg::move_cmd_t slot,
  output logic                  slot_valid,
  output logic                  buffer_dtr
);
  import motion_pkg::*;

  localparam int ptr_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1;

  move_cmd_t           slots [buffer_size];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [ptr_bits:0]   count;
  logic                full;
  logic                accept;
  logic                retire;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
    if (p == ptr_bits'(buffer_size - 1)) return '0;
    return p + 1'b1;
  endfunction

  assign full       = (count == (ptr_bits + 1)'(buffer_size));
  assign accept     = push && !full;      // Full pushes are lost
  assign retire     = take && slot_valid;
  assign slot_valid = (count != '0);
  assign buffer_dtr = !full;
  assign slot       = slots[rd_ptr];      // Oldest move

  always_ff @(posedge CLK) begin
    if (accept) slots[wr_ptr] <= move;
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) wr_ptr <= next_ptr(wr_ptr);
      if (retire) rd_ptr <= next_ptr(rd_ptr);
      case ({accept, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Sequencer may only free a slot that holds a move
  a_take_valid: assert property (@(posedge CLK) disable iff (resetn)
    take |-> slot_valid);

endmodule

//--- verilog/dda_axis.sv
// One DDA axis; steps equal floor(duration x increment / 2^dda_bits) and position wraps at 32 bits
`timescale 1ns/1ps

module dda_axis (
  input  logic                                       CLK,
  input  logic                                       resetn,
  input  motion_pkg::axis_ctrl_t                     axis_ctrl,
  input  logic [motion_pkg::dda_bits-1:0]            increment,
  input  logic                                       dir,
  output logic                                       step,
  output logic signed [motion_pkg::position_bits-1:0] position
);
  import motion_pkg::*;

  logic [dda_bits-1:0] accum;
  logic [dda_bits:0]   sum;  // Top bit is the carry

  assign sum = {1'b0, accum} + {1'b0, increment};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum    <= '0;
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= 1'b0;
      if (axis_ctrl.load) begin
        accum <= '0;  // Fresh move
      end else if (axis_ctrl.tick && axis_ctrl.running) begin
        accum <= sum[dda_bits-1:0];
        if (sum[dda_bits]) begin
          step <= 1'b1;
          // Forward counts up
          if (dir) position <= position + 1;
          else position <= position - 1;
        end
      end
    end
  end

  // Step follows a running tick from the sequencer
  a_step_on_tick: assert property (@(posedge CLK) disable iff (resetn)
    step |-> $past(axis_ctrl.tick && axis_ctrl.running));

endmodule

//--- verilog/motion_pkg.sv
// Motion pipeline types; arrays are sized for max_motors and only num_motors entries are live
package motion_pkg;

  // Upper bound on axes
  localparam int max_motors = 4;

  localparam int dda_bits      = 32;  // Accumulator and increment width
  localparam int position_bits = 32;
  localparam int duration_bits = 32;  // Move length in DDA ticks

  // One buffered move
  typedef struct packed {
    logic [duration_bits-1:0]                 duration;
    logic [max_motors-1:0]                    dir_mask;    // 1 moves forward
    logic [max_motors-1:0][dda_bits-1:0]      increments;  // Indexed by axis
  } move_cmd_t;

  // Broadcast from sequencer to every axis
  typedef struct packed {
    logic tick;
    logic load;
    logic running;
  } axis_ctrl_t;

  typedef logic signed [position_bits-1:0] position_t;

  // Per-axis positions
  typedef position_t [max_motors-1:0] position_vec_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    idle,
    load,
    run
  } seq_state_e;

endpackage

//--- verilog/spi_protocol_pkg.sv
// Host word protocol constants; the opcode is the top byte of a header word and indices the low byte
package spi_protocol_pkg;

  // Host word
  localparam int word_bits = 64;

  typedef logic [word_bits-1:0] word_t;

  // Header opcodes
  typedef enum logic [7:0] {
    cmd_coordinated_step = 8'h01,
    cmd_status_reg       = 8'hF1,
    cmd_config_reg       = 8'hF2
  } opcode_e;

  // Status register indices
  localparam int status_version        = 0;
  localparam int status_channel_info   = 1;
  localparam int status_position_start = 2;  // Axis n sits at 2+n

  // Config register indices
  localparam int config_enable = 0;
  localparam int config_clocks = 1;

  // DDA tick divisor after reset
  localparam logic [7:0] default_clock_divisor = 8'd32;

  // Version bytes
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd0;
  localparam logic [7:0] version_patch = 8'd0;

  localparam word_t version_word = {
    {(word_bits - 24){1'b0}},
    version_major,
    version_minor,
    version_patch
  };

endpackage
